//--- logic/cp0_params.svh
`ifndef CP0_PARAMS_SVH
`define CP0_PARAMS_SVH

`define WORD_W          32
`define CP0_ADDR_W      5
`define HW_INT_W        6

// CP0 register numbers
`define CP0_BADVADDR    5'd8
`define CP0_COUNT       5'd9
`define CP0_COMPARE     5'd11
`define CP0_STATUS      5'd12
`define CP0_CAUSE       5'd13
`define CP0_EPC         5'd14
`define CP0_PRID        5'd15

// Status fields
`define ST_CU0          28
`define ST_BEV          22
`define ST_IM           15:8
`define ST_UM           4
`define ST_ERL          2
`define ST_EXL          1
`define ST_IE           0

// Cause fields that software may write
`define CAUSE_IV        23
`define CAUSE_IP_SW     9:8

// ExcCode values
`define EXC_INT         5'd0
`define EXC_ADEL        5'd4
`define EXC_ADES        5'd5
`define EXC_SYS         5'd8
`define EXC_BP          5'd9
`define EXC_RI          5'd10
`define EXC_CPU         5'd11
`define EXC_OV          5'd12
`define EXC_TR          5'd13

`define PRID_VALUE      32'h00018000
`define STATUS_RESET    32'h00400004   // BEV and ERL set
`define ZERO_WORD       32'h00000000

`endif

//--- logic/cp0Pkg.sv
`include "cp0_params.svh"

package cp0Pkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`CP0_ADDR_W-1:0] cp0Addr_t;
    typedef logic [4:0]             excCode_t;

    // Exception kinds seen by CP0, ERET rides on the same strobe
    typedef enum logic [3:0] {
        typeInt  = 4'd0,
        typeCpU  = 4'd1,
        typeRi   = 4'd2,
        typeOv   = 4'd3,
        typeTrap = 4'd4,
        typeSys  = 4'd5,
        typeBp   = 4'd6,
        typeAdEL = 4'd7,
        typeAdES = 4'd8,
        typeEret = 4'd9
    } excType_t;

    typedef struct packed {
        logic [2:0] pad31;
        logic       cu0;     // 28
        logic [4:0] pad27;
        logic       bev;     // 22
        logic [5:0] pad21;
        logic [7:0] im;      // 15:8
        logic [2:0] pad7;
        logic       um;      // 4
        logic       pad3;
        logic       erl;     // 2
        logic       exl;     // 1
        logic       ie;      // 0
    } statusReg_t;

    typedef struct packed {
        logic       bd;      // 31
        logic       pad30;
        logic [1:0] ce;      // 29:28
        logic [3:0] pad27;
        logic       iv;      // 23
        logic [6:0] pad22;
        logic [7:0] ip;      // 15:8, upper six from hardware
        logic       pad7;
        excCode_t   excCode; // 6:2
        logic [1:0] pad1;
    } causeReg_t;

    typedef struct packed {
        logic       valid;
        excType_t   excType;
        word_t      pc;
        word_t      badAddr;
        logic [1:0] cpNum;
        logic       inSlot;
    } excReq_t;

    typedef struct packed {
        logic     en;
        cp0Addr_t addr;
        word_t    data;
    } regWrite_t;

endpackage

//--- logic/excStatusUnit.sv
`timescale 1ns/1ps
`include "cp0_params.svh"

module excStatusUnit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`HW_INT_W-1:0] intr_i,
    input  cp0Pkg::regWrite_t    wr_i,
    input  cp0Pkg::excReq_t      exc_i,
    output cp0Pkg::statusReg_t   status_o,
    output cp0Pkg::causeReg_t    cause_o,
    output cp0Pkg::word_t        epc_o,
    output cp0Pkg::word_t        badVAddr_o,
    output logic                 userMode_o
);

    cp0Pkg::statusReg_t status;
    cp0Pkg::causeReg_t  cause;
    cp0Pkg::word_t      epc;
    cp0Pkg::word_t      badVAddr;
    cp0Pkg::word_t      pcMinus4;
    cp0Pkg::excCode_t   excCode;
    logic               excKept;
    logic               isAddrErr;

    assign pcMinus4 = exc_i.pc - 32'd4;

    // Map exception kind to ExcCode
    always_comb begin
        excKept = 1'b1;
        excCode = `EXC_INT;
        case (exc_i.excType)
            cp0Pkg::typeInt:  excCode = `EXC_INT;
            cp0Pkg::typeCpU:  excCode = `EXC_CPU;
            cp0Pkg::typeRi:   excCode = `EXC_RI;
            cp0Pkg::typeOv:   excCode = `EXC_OV;
            cp0Pkg::typeTrap: excCode = `EXC_TR;
            cp0Pkg::typeSys:  excCode = `EXC_SYS;
            cp0Pkg::typeBp:   excCode = `EXC_BP;
            cp0Pkg::typeAdEL: excCode = `EXC_ADEL;
            cp0Pkg::typeAdES: excCode = `EXC_ADES;
            default:          excKept = 1'b0;  // ERET or unused encoding
        endcase
    end

    assign isAddrErr = (exc_i.excType == cp0Pkg::typeAdEL) ||
                       (exc_i.excType == cp0Pkg::typeAdES);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status   <= cp0Pkg::statusReg_t'(`STATUS_RESET);
            cause    <= '0;
            epc      <= '0;
            badVAddr <= '0;
        end else begin
            cause.ip[7:2] <= intr_i;  // Sampled every cycle

            if (exc_i.valid) begin
                if (excKept) begin
                    // Nested exception keeps the first EPC
                    if (!status.exl) begin
                        epc      <= exc_i.inSlot ? pcMinus4 : exc_i.pc;
                        cause.bd <= exc_i.inSlot;
                    end
                    status.exl    <= 1'b1;
                    cause.excCode <= excCode;
                    if (exc_i.excType == cp0Pkg::typeCpU)
                        cause.ce <= exc_i.cpNum;
                    if (isAddrErr)
                        badVAddr <= exc_i.badAddr;
                end else if (exc_i.excType == cp0Pkg::typeEret) begin
                    status.exl <= 1'b0;
                end
            end else if (wr_i.en) begin
                case (wr_i.addr)
                    `CP0_STATUS: begin
                        status.cu0 <= wr_i.data[`ST_CU0];
                        status.bev <= wr_i.data[`ST_BEV];
                        status.im  <= wr_i.data[`ST_IM];
                        status.um  <= wr_i.data[`ST_UM];
                        status.erl <= wr_i.data[`ST_ERL];
                        status.exl <= wr_i.data[`ST_EXL];
                        status.ie  <= wr_i.data[`ST_IE];
                    end
                    `CP0_CAUSE: begin
                        cause.iv      <= wr_i.data[`CAUSE_IV];
                        cause.ip[1:0] <= wr_i.data[`CAUSE_IP_SW];  // Software interrupts
                    end
                    `CP0_EPC:      epc      <= wr_i.data;
                    `CP0_BADVADDR: badVAddr <= wr_i.data;
                    default: ;  // Other numbers live elsewhere
                endcase
            end
        end
    end

    assign userMode_o = status.um & ~(status.erl | status.exl);
    assign status_o   = status;
    assign cause_o    = cause;
    assign epc_o      = epc;
    assign badVAddr_o = badVAddr;

endmodule

//--- logic/countCompareTimer.sv
`timescale 1ns/1ps
`include "cp0_params.svh"

module countCompareTimer (
    input  logic              clk,
    input  logic              rst,
    input  cp0Pkg::regWrite_t wr_i,
    output cp0Pkg::word_t     count_o,
    output cp0Pkg::word_t     compare_o,
    output logic              timerInt_o
);

    cp0Pkg::word_t count;
    cp0Pkg::word_t compare;
    logic          timerInt;
    logic          wrCount;
    logic          wrCompare;
    logic          hit;

    assign wrCount   = wr_i.en && (wr_i.addr == `CP0_COUNT);
    assign wrCompare = wr_i.en && (wr_i.addr == `CP0_COMPARE);
    assign hit       = (compare != `ZERO_WORD) && (compare == count);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count    <= '0;
            compare  <= '0;
            timerInt <= 1'b0;
        end else begin
            count <= wrCount ? wr_i.data : count + 32'd1;

            // Compare write acknowledges the interrupt
            if (wrCompare) begin
                compare  <= wr_i.data;
                timerInt <= 1'b0;
            end else if (hit) begin
                timerInt <= 1'b1;  // Sticky
            end
        end
    end

    assign count_o    = count;
    assign compare_o  = compare;
    assign timerInt_o = timerInt;

endmodule

//--- logic/cp0ReadMux.sv
`timescale 1ns/1ps
`include "cp0_params.svh"

module cp0ReadMux (
    input  cp0Pkg::cp0Addr_t   rdAddr_i,
    input  cp0Pkg::statusReg_t status_i,
    input  cp0Pkg::causeReg_t  cause_i,
    input  cp0Pkg::word_t      epc_i,
    input  cp0Pkg::word_t      badVAddr_i,
    input  cp0Pkg::word_t      count_i,
    input  cp0Pkg::word_t      compare_i,
    output cp0Pkg::word_t      rdata_o
);

    cp0Pkg::word_t rdata;

    // Purely combinational read port
    always_comb begin
        case (rdAddr_i)
            `CP0_BADVADDR: rdata = badVAddr_i;
            `CP0_COUNT:    rdata = count_i;
            `CP0_COMPARE:  rdata = compare_i;
            `CP0_STATUS:   rdata = status_i;
            `CP0_CAUSE:    rdata = cause_i;
            `CP0_EPC:      rdata = epc_i;
            `CP0_PRID:     rdata = `PRID_VALUE;
            default:       rdata = `ZERO_WORD;  // Unimplemented registers
        endcase
    end

    assign rdata_o = rdata;

endmodule

//--- logic/cp0Top.sv
`timescale 1ns/1ps
`include "cp0_params.svh"

module cp0Top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`HW_INT_W-1:0] intr_i,
    input  cp0Pkg::regWrite_t    wr_i,
    input  cp0Pkg::excReq_t      exc_i,
    input  cp0Pkg::cp0Addr_t     rdAddr_i,
    output cp0Pkg::word_t        rdata_o,
    output cp0Pkg::statusReg_t   status_o,
    output cp0Pkg::causeReg_t    cause_o,
    output cp0Pkg::word_t        epc_o,
    output logic                 userMode_o,
    output logic                 timerInt_o
);

    cp0Pkg::word_t badVAddr;
    cp0Pkg::word_t count;
    cp0Pkg::word_t compare;

    excStatusUnit uExcStatus (
        .clk        (clk),
        .rst        (rst),
        .intr_i     (intr_i),
        .wr_i       (wr_i),
        .exc_i      (exc_i),
        .status_o   (status_o),
        .cause_o    (cause_o),
        .epc_o      (epc_o),
        .badVAddr_o (badVAddr),
        .userMode_o (userMode_o)
    );

    countCompareTimer uTimer (
        .clk        (clk),
        .rst        (rst),
        .wr_i       (wr_i),
        .count_o    (count),
        .compare_o  (compare),
        .timerInt_o (timerInt_o)
    );

    cp0ReadMux uReadMux (
        .rdAddr_i   (rdAddr_i),
        .status_i   (status_o),
        .cause_i    (cause_o),
        .epc_i      (epc_o),
        .badVAddr_i (badVAddr),
        .count_i    (count),
        .compare_i  (compare),
        .rdata_o    (rdata_o)
    );

endmodule

//--- testbench/cp0_assert.sv
`timescale 1ns/1ps
`include "cp0_params.svh"

module cp0Assert (
    input logic               clk,
    input logic               rst,
    input cp0Pkg::regWrite_t  wr_i,
    input cp0Pkg::excReq_t    exc_i,
    input cp0Pkg::cp0Addr_t   rdAddr_i,
    input cp0Pkg::word_t      rdata_o,
    input cp0Pkg::statusReg_t status_o,
    input logic               userMode_o,
    input logic               timerInt_o
);

    int failCount = 0;

    userModeDerived: assert property (@(posedge clk) disable iff (rst)
        userMode_o == (status_o.um && !status_o.erl && !status_o.exl))
    else begin
        $error("userMode_o does not follow status_o");
        failCount++;
    end

    // Compare write acknowledges the timer
    timerAck: assert property (@(posedge clk) disable iff (rst)
        (wr_i.en && wr_i.addr == `CP0_COMPARE) |=> !timerInt_o)
    else begin
        $error("timerInt_o high after a Compare write");
        failCount++;
    end

    exlOnEntry: assert property (@(posedge clk) disable iff (rst)
        (exc_i.valid && exc_i.excType <= cp0Pkg::typeAdES) |=> status_o.exl)
    else begin
        $error("EXL not set after an exception");
        failCount++;
    end

    pridConst: assert property (@(posedge clk) disable iff (rst)
        (rdAddr_i == `CP0_PRID) |-> (rdata_o == `PRID_VALUE))
    else begin
        $error("PrId read returned a wrong value");
        failCount++;
    end

endmodule

bind cp0Top cp0Assert uAssert (.*);

//--- testbench/cp0Tb.sv
`timescale 1ns/1ps
`include "cp0_params.svh"

module cp0Tb;

    logic                 clk;
    logic                 rst;
    logic [`HW_INT_W-1:0] intr;
    cp0Pkg::regWrite_t    wr;
    cp0Pkg::excReq_t      exc;
    cp0Pkg::cp0Addr_t     rdAddr;
    cp0Pkg::word_t        rdata;
    cp0Pkg::statusReg_t   status;
    cp0Pkg::causeReg_t    cause;
    cp0Pkg::word_t        epc;
    logic                 userMode;
    logic                 timerInt;
    int                   lineCount = 0;

    cp0Top UUT (
        .clk        (clk),
        .rst        (rst),
        .intr_i     (intr),
        .wr_i       (wr),
        .exc_i      (exc),
        .rdAddr_i   (rdAddr),
        .rdata_o    (rdata),
        .status_o   (status),
        .cause_o    (cause),
        .epc_o      (epc),
        .userMode_o (userMode),
        .timerInt_o (timerInt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "Run aborted");
    endtask

    task automatic checkWord(input string name, input cp0Pkg::word_t got,
                             input cp0Pkg::word_t exp);
        if (got !== exp)
            abortRun($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic checkStatus(input string name, input cp0Pkg::statusReg_t got,
                               input cp0Pkg::statusReg_t exp);
        if (got !== exp)
            abortRun($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic checkCause(input string name, input cp0Pkg::causeReg_t got,
                              input cp0Pkg::causeReg_t exp);
        if (got !== exp)
            abortRun($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abortRun($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    // Strobes last one cycle
    task automatic step(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            wr.en     = 1'b0;
            wr.data   = $urandom();  // Idle data must not land anywhere
            exc.valid = 1'b0;
        end
    endtask

    initial begin
        wait (lineCount > 0);
        #(lineCount * 64 * 100);
        abortRun("Timeout, the golden file was not finished in time");
    end

    initial begin
        int          fd;
        int          n;
        int          i;
        string       op;
        string       line;
        logic [31:0] f [0:6];

        void'($urandom(36736));
        rst    = 1'b1;
        intr   = '0;
        wr     = '0;
        exc    = '0;
        rdAddr = '0;
        fd = $fopen("testbench/cp0_golden.txt", "r");
        if (fd == 0)
            abortRun("Could not open testbench/cp0_golden.txt");
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0)
                lineCount++;
        end
        $fclose(fd);
        fd = $fopen("testbench/cp0_golden.txt", "r");
        repeat (16) @(negedge clk);
        rst = 1'b0;

        while ($fscanf(fd, "%s", op) == 1) begin
            case (op)
                "#": n = $fgets(line, fd);
                "W": begin
                    n = $fscanf(fd, "%h %h", f[0], f[1]);
                    wr = '{en: 1'b1, addr: f[0][4:0], data: f[1]};
                    step(1);
                end
                "E": begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                    exc = '{valid: 1'b1, excType: cp0Pkg::excType_t'(f[0][3:0]), pc: f[1],
                            badAddr: f[2], cpNum: f[3][1:0], inSlot: f[4][0]};
                    if (f[5] != 0)
                        wr = '{en: 1'b1, addr: f[5][4:0], data: f[6]};  // Same cycle
                    step(1);
                end
                "I": begin
                    n = $fscanf(fd, "%h", f[0]);
                    intr = f[0][`HW_INT_W-1:0];
                end
                "N": begin
                    n = $fscanf(fd, "%h", f[0]);
                    step(f[0]);
                end
                "R": begin
                    n = $fscanf(fd, "%h %h", f[0], f[1]);
                    rdAddr = f[0][4:0];
                    #25;  // Mux settles
                    checkWord($sformatf("rdata_o[%0d]", f[0]), rdata, f[1]);
                    if (f[0][4:0] == `CP0_EPC)
                        checkWord("epc_o", epc, f[1]);
                    step(1);
                end
                "S": begin
                    n = $fscanf(fd, "%h", f[0]);
                    checkStatus("status_o", status, f[0]);
                end
                "C": begin
                    n = $fscanf(fd, "%h", f[0]);
                    checkCause("cause_o", cause, f[0]);
                end
                "U": begin
                    n = $fscanf(fd, "%h", f[0]);
                    checkBit("userMode_o", userMode, f[0][0]);
                end
                "T": begin
                    n = $fscanf(fd, "%h %h", f[0], f[1]);
                    i = 0;
                    while (timerInt !== f[0][0] && i < f[1]) begin
                        step(1);
                        i++;
                    end
                    if (timerInt !== f[0][0])
                        abortRun($sformatf("timerInt_o did not become %0d within %0d cycles",
                                           f[0][0], f[1]));
                end
                default: abortRun({"Unknown operation in the golden file: ", op});
            endcase
            if (n < 1)
                abortRun({"Missing fields after operation in the golden file: ", op});
        end
        $fclose(fd);

        if (UUT.uAssert.failCount != 0) begin
            abortRun($sformatf("%0d assertion failures in the run", UUT.uAssert.failCount));
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- testbench/cp0_golden.txt
# W addr data | E type pc badAddr cpNum inSlot wrAddr wrData | I lines | N cycles
# R addr expData | S expStatus | C expCause | U expUserMode | T expTimerInt maxCycles
S 00400004
U 0
C 00000000
R 0e 00000000
R 0b 00000000
R 0f 00018000
R 03 00000000
W 0d ffffffff
C 00800300
W 0e 12345678
R 0e 12345678
W 08 deadbeef
R 08 deadbeef
W 0b 00001000
R 0b 00001000
W 0c 1000ff11
R 0c 1000ff11
U 1
E 3 80001000 0 0 0 0 0
C 00800330
R 0e 80001000
E 1 80002000 0 2 1 0 0
C 2080032c
R 0e 80001000
E 9 0 0 0 0 0 0
U 1
E 7 80003004 abc 0 1 0 0
C a0800310
R 08 00000abc
R 0e 80003000
E 0 80005000 0 0 0 0 0
C a0800300
E 2 80005004 0 0 0 0 0
C a0800328
E 4 80005008 0 0 0 0 0
C a0800334
E 5 8000500c 0 0 0 0c 00000000
C a0800320
S 1000ff13
E 6 80005010 0 0 0 0 0
C a0800324
E 8 80005014 def 0 0 0 0
C a0800314
R 08 00000def
I 2a
N 1
C a080ab14
W 0b 00002000
W 09 00001ffb
T 1 7
T 1 0
W 0b 00003000
T 0 0

//--- compile.f
+incdir+logic
logic/cp0Pkg.sv
logic/excStatusUnit.sv
logic/countCompareTimer.sv
logic/cp0ReadMux.sv
logic/cp0Top.sv
testbench/cp0_assert.sv
testbench/cp0Tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the CP0 testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert -f compile.f --top-module cp0Tb -o cp0Sim
	./obj_dir/cp0Sim | tee /dev/stderr | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
